// File: logic/pvr_pkg.sv
`default_nettype none

package pvr_pkg;

	localparam int ADDR_BITS = 16;	// host byte address width
	localparam int WORD_BITS = 32;	// host data width

	typedef logic [ADDR_BITS-1:0] pvr_addr_t;	// byte offset into the pvr space
	typedef logic [WORD_BITS-1:0] pvr_word_t;	// one register or palette word

	// register window, word aligned byte offsets
	localparam pvr_addr_t ID_ADDR        = 16'h0000;	// R  device id
	localparam pvr_addr_t REVISION_ADDR  = 16'h0004;	// R  revision number
	localparam pvr_addr_t REG_WINDOW_END = 16'h03FC;	// last word of the window

	// palette ram, one word per entry
	localparam pvr_addr_t PAL_BASE = 16'h1000;	// first palette word
	localparam pvr_addr_t PAL_END  = 16'h1FFC;	// last palette word

	// fixed read-only contents
	localparam pvr_word_t ID_VALUE       = 32'h17FD11DB;	// device id
	localparam pvr_word_t REVISION_VALUE = 32'h00000011;	// silicon revision

	// default sizes, top level may override
	localparam int REG_WORDS_DEFAULT     = 256;		// 0x0000..0x03FC
	localparam int PAL_WORDS_DEFAULT     = 1024;	// 0x1000..0x1FFC
	localparam int TA_FIFO_DEPTH_DEFAULT = 256;		// command list words, power of two

endpackage

`default_nettype wire

// File: logic/pvr_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface pvr_bus_if import pvr_pkg::*; #(
	parameter int INDEX_W = 8	// word index width of the target
) ();

	logic [INDEX_W-1:0] word_index;	// word address inside the target
	pvr_word_t          wdata;		// write data
	logic               wr;			// one-cycle write strobe
	pvr_word_t          rdata;		// read data, follows word_index

	modport initiator (
		output word_index,
		output wdata,
		output wr,
		input  rdata
	);

	modport target (
		input  word_index,
		input  wdata,
		input  wr,
		output rdata
	);

endinterface

`default_nettype wire

// File: logic/pvr_bus_decode.sv
`timescale 1ns/1ps
`default_nettype none

module pvr_bus_decode import pvr_pkg::*; #(
	parameter int REG_WORDS = REG_WORDS_DEFAULT,
	parameter int PAL_WORDS = PAL_WORDS_DEFAULT
) (
	input  wire            pvr_reg_cs_i,	// host chip select
	input  wire pvr_addr_t pvr_addr_i,		// host byte address
	input  wire pvr_word_t pvr_din_i,
	input  wire            pvr_rd_i,
	input  wire            pvr_wr_i,
	output pvr_word_t      pvr_dout_o,		// combinational read data

	pvr_bus_if.initiator   reg_bus,		// register window
	pvr_bus_if.initiator   pal_bus		// palette ram
);

	localparam int REG_IDX_W = $clog2(REG_WORDS);
	localparam int PAL_IDX_W = $clog2(PAL_WORDS);

	typedef enum logic [1:0] {
		REGION_NONE,	// unmapped, reads zero
		REGION_REG,
		REGION_PAL
	} region_t;

	pvr_addr_t word_addr;	// address with byte lanes cleared
	region_t   region;
	logic      host_wr;		// qualified host write
	logic      rd_sel;		// qualified host read

	assign word_addr = {pvr_addr_i[ADDR_BITS-1:2], 2'b00};
	assign host_wr   = pvr_reg_cs_i & pvr_wr_i;
	assign rd_sel    = pvr_reg_cs_i & pvr_rd_i;

	always_comb begin
		if (word_addr <= REG_WINDOW_END) begin
			region = REGION_REG;
		end else if (word_addr >= PAL_BASE && word_addr <= PAL_END) begin
			region = REGION_PAL;
		end else begin
			region = REGION_NONE;	// includes the old object-list pointer area
		end
	end

	// word indexed, byte offset bits [1:0] dropped
	assign reg_bus.word_index = pvr_addr_i[REG_IDX_W+1:2];
	assign pal_bus.word_index = pvr_addr_i[PAL_IDX_W+1:2];	// base is 4k aligned
	assign reg_bus.wdata      = pvr_din_i;
	assign pal_bus.wdata      = pvr_din_i;
	assign reg_bus.wr         = host_wr && (region == REGION_REG);	// only the hit target
	assign pal_bus.wr         = host_wr && (region == REGION_PAL);

	always_comb begin
		pvr_dout_o = '0;	// idle bus reads zero
		if (rd_sel) begin
			case (region)
				REGION_REG: pvr_dout_o = reg_bus.rdata;
				REGION_PAL: pvr_dout_o = pal_bus.rdata;
				default:    pvr_dout_o = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/pvr_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module pvr_reg_file import pvr_pkg::*; #(
	parameter int REG_WORDS = REG_WORDS_DEFAULT
) (
	input wire         clock,
	input wire         reset_n,

	pvr_bus_if.target  bus
);

	localparam int IDX_W = $clog2(REG_WORDS);

	localparam logic [IDX_W-1:0] ID_IDX  = IDX_W'(ID_ADDR >> 2);		// word 0
	localparam logic [IDX_W-1:0] REV_IDX = IDX_W'(REVISION_ADDR >> 2);	// word 1

	pvr_word_t regs [REG_WORDS];	// plain r/w storage, gaps included
	logic      fixed_hit;			// id or revision selected

	assign fixed_hit = (bus.word_index == ID_IDX) || (bus.word_index == REV_IDX);

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			for (int i = 0; i < REG_WORDS; i++) begin
				regs[i] <= '0;
			end
		end else if (bus.wr && !fixed_hit) begin	// id and revision are read only
			regs[bus.word_index] <= bus.wdata;
		end
	end

	// read path, zero latency
	always_comb begin
		case (bus.word_index)
			ID_IDX:  bus.rdata = ID_VALUE;
			REV_IDX: bus.rdata = REVISION_VALUE;
			default: bus.rdata = regs[bus.word_index];
		endcase
	end

endmodule

`default_nettype wire

// File: logic/pvr_palette_ram.sv
`timescale 1ns/1ps
`default_nettype none

module pvr_palette_ram import pvr_pkg::*; #(
	parameter int PAL_WORDS = PAL_WORDS_DEFAULT
) (
	input wire         clock,

	pvr_bus_if.target  bus
);

	pvr_word_t pal_ram [PAL_WORDS];	// one colour entry per word

	always_ff @(posedge clock) begin
		if (bus.wr) begin
			pal_ram[bus.word_index] <= bus.wdata;	// visible next cycle
		end
	end

	assign bus.rdata = pal_ram[bus.word_index];	// async read

endmodule

`default_nettype wire

// File: logic/ta_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module ta_fifo import pvr_pkg::*; #(
	parameter int TA_FIFO_DEPTH = TA_FIFO_DEPTH_DEFAULT
) (
	input  wire        clock,
	input  wire        reset_n,

	input  wire        write_i,		// push that is dropped when full
	input  wire pvr_word_t data_i,
	input  wire        read_i,		// pop that is ignored when empty
	output pvr_word_t  data_o,		// last popped word

	output logic       full_o,
	output logic       empty_o,
	output logic [$clog2(TA_FIFO_DEPTH+1)-1:0] words_o	// occupancy
);

	localparam int ADDR_W = $clog2(TA_FIFO_DEPTH);
	localparam int CNT_W  = $clog2(TA_FIFO_DEPTH+1);

	pvr_word_t         mem [TA_FIFO_DEPTH];
	logic [ADDR_W:0]   wr_ptr;		// msb is the wrap bit
	logic [ADDR_W:0]   rd_ptr;
	logic [ADDR_W:0]   wr_ptr_next;
	logic [ADDR_W:0]   rd_ptr_next;
	logic              push;
	logic              pop;

	assign push = write_i & ~full_o;
	assign pop  = read_i & ~empty_o;

	assign wr_ptr_next = wr_ptr + (ADDR_W+1)'(push);
	assign rd_ptr_next = rd_ptr + (ADDR_W+1)'(pop);

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr[ADDR_W-1:0]] <= data_i;
		end
	end

	// status is registered from the next pointers so it moves on the same edge
	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			full_o  <= 1'b0;
			empty_o <= 1'b1;
			words_o <= '0;
			data_o  <= '0;
		end else begin
			wr_ptr  <= wr_ptr_next;
			rd_ptr  <= rd_ptr_next;
			empty_o <= (wr_ptr_next == rd_ptr_next);
			full_o  <= (wr_ptr_next[ADDR_W] != rd_ptr_next[ADDR_W]) &&
				(wr_ptr_next[ADDR_W-1:0] == rd_ptr_next[ADDR_W-1:0]);	// same slot on the other lap
			words_o <= CNT_W'(wr_ptr_next - rd_ptr_next);
			if (pop) begin
				data_o <= mem[rd_ptr[ADDR_W-1:0]];	// held until the next pop
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/pvr_top.sv
`timescale 1ns/1ps
`default_nettype none

module pvr_top import pvr_pkg::*; #(
	parameter int REG_WORDS     = REG_WORDS_DEFAULT,
	parameter int PAL_WORDS     = PAL_WORDS_DEFAULT,
	parameter int TA_FIFO_DEPTH = TA_FIFO_DEPTH_DEFAULT
) (
	input  wire            clock,
	input  wire            reset_n,

	// host register bus
	input  wire            pvr_reg_cs_i,
	input  wire pvr_addr_t pvr_addr_i,
	input  wire pvr_word_t pvr_din_i,
	input  wire            pvr_rd_i,
	input  wire            pvr_wr_i,
	output pvr_word_t      pvr_dout_o,

	// command list fifo
	input  wire            ta_fifo_wr_i,	// pushes pvr_din_i
	input  wire            ta_rd_i,			// ta accelerator pop
	output pvr_word_t      ta_data_o,
	output logic           ta_full_o,
	output logic           ta_empty_o,
	output logic [$clog2(TA_FIFO_DEPTH+1)-1:0] ta_words_o
);

	pvr_bus_if #(.INDEX_W($clog2(REG_WORDS))) reg_bus ();	// decoder to register file
	pvr_bus_if #(.INDEX_W($clog2(PAL_WORDS))) pal_bus ();	// decoder to palette

	pvr_bus_decode #(
		.REG_WORDS    (REG_WORDS),
		.PAL_WORDS    (PAL_WORDS)
	) u_bus_decode (
		.pvr_reg_cs_i (pvr_reg_cs_i),
		.pvr_addr_i   (pvr_addr_i),
		.pvr_din_i    (pvr_din_i),
		.pvr_rd_i     (pvr_rd_i),
		.pvr_wr_i     (pvr_wr_i),
		.pvr_dout_o   (pvr_dout_o),
		.reg_bus      (reg_bus.initiator),
		.pal_bus      (pal_bus.initiator)
	);

	pvr_reg_file #(
		.REG_WORDS (REG_WORDS)
	) u_reg_file (
		.clock     (clock),
		.reset_n   (reset_n),
		.bus       (reg_bus.target)
	);

	pvr_palette_ram #(
		.PAL_WORDS (PAL_WORDS)
	) u_palette_ram (
		.clock     (clock),
		.bus       (pal_bus.target)
	);

	ta_fifo #(
		.TA_FIFO_DEPTH (TA_FIFO_DEPTH)
	) u_ta_fifo (
		.clock         (clock),
		.reset_n       (reset_n),
		.write_i       (ta_fifo_wr_i),	// fifo strobe alone qualifies the push
		.data_i        (pvr_din_i),
		.read_i        (ta_rd_i),
		.data_o        (ta_data_o),
		.full_o        (ta_full_o),
		.empty_o       (ta_empty_o),
		.words_o       (ta_words_o)
	);

endmodule

`default_nettype wire

// File: testbench/pvr_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module pvr_assertions import pvr_pkg::*; #(
	parameter int DEPTH = TA_FIFO_DEPTH_DEFAULT	// fifo depth of the bound instance
) (
	input wire                       clock,
	input wire                       reset_n,
	input wire                       read_i,		// pop request
	input wire pvr_word_t            data_o,		// last popped word
	input wire                       full_o,
	input wire                       empty_o,
	input wire [$clog2(DEPTH+1)-1:0] words_o		// occupancy
);

	int fail_count = 0;	// failed checks so far

	full_empty_exclusive: assert property (@(posedge clock) disable iff (!reset_n)
		!(full_o && empty_o))
		else begin
			$error("fifo reports full and empty together");
			fail_count++;
		end

	count_in_range: assert property (@(posedge clock) disable iff (!reset_n)
		words_o <= DEPTH)
		else begin
			$error("fifo word count above depth");
			fail_count++;
		end

	// data_o only moves on an accepted pop
	data_held: assert property (@(posedge clock) disable iff (!reset_n)
		!(read_i && !empty_o) |=> $stable(data_o))
		else begin
			$error("fifo data output changed without a pop");
			fail_count++;
		end

endmodule

bind ta_fifo pvr_assertions #(
	.DEPTH   (TA_FIFO_DEPTH)
) u_fifo_assertions (
	.clock   (clock),
	.reset_n (reset_n),
	.read_i  (read_i),
	.data_o  (data_o),
	.full_o  (full_o),
	.empty_o (empty_o),
	.words_o (words_o)
);

`default_nettype wire

// File: testbench/pvr_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pvr_tb import pvr_pkg::*; ();

	localparam int REG_WORDS  = REG_WORDS_DEFAULT;
	localparam int PAL_WORDS  = PAL_WORDS_DEFAULT;
	localparam int DEPTH      = TA_FIFO_DEPTH_DEFAULT;
	localparam int WAIT_LIMIT = 2 * DEPTH + 64;	// cycles before a wait gives up

	typedef logic [$clog2(DEPTH+1)-1:0] count_t;	// same width as ta_words_o

	logic        clock;
	logic        reset_n;
	logic        pvr_reg_cs_i;
	pvr_addr_t   pvr_addr_i;
	pvr_word_t   pvr_din_i;
	logic        pvr_rd_i;
	logic        pvr_wr_i;
	pvr_word_t   pvr_dout_o;
	logic        ta_fifo_wr_i;
	logic        ta_rd_i;
	pvr_word_t   ta_data_o;
	logic        ta_full_o;
	logic        ta_empty_o;
	count_t      ta_words_o;

	pvr_word_t   reg_model [REG_WORDS];	// expected register window
	pvr_word_t   pal_model [PAL_WORDS];	// expected palette
	pvr_word_t   fifo_q [$];			// expected fifo contents
	pvr_word_t   fifo_last;				// expected ta_data_o
	logic        can_pop;
	logic        can_push;
	logic [31:0] seed = 32'h333;
	int          error_count = 0;
	int          test_errors = 0;		// error_count when the current test began
	int          tests_passed = 0;
	int          tests_failed = 0;
	int          assert_fails;

	pvr_top #(
		.REG_WORDS     (REG_WORDS),
		.PAL_WORDS     (PAL_WORDS),
		.TA_FIFO_DEPTH (DEPTH)
	) u_pvr_top (.*);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;	// 4 ns period
	end

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;	// lcg step
		return seed;
	endfunction

	// expected host read data from the address map
	function automatic pvr_word_t expected_read(pvr_addr_t addr, logic cs, logic rd);
		pvr_addr_t offset;
		offset = addr & 16'hFFFC;	// byte lanes ignored
		if (!(cs && rd)) return '0;
		if (offset == ID_ADDR) return ID_VALUE;
		if (offset == REVISION_ADDR) return REVISION_VALUE;
		if (offset <= REG_WINDOW_END) return reg_model[offset >> 2];
		if (offset >= PAL_BASE && offset <= PAL_END) return pal_model[(offset - PAL_BASE) >> 2];
		return '0;	// unmapped
	endfunction

	function automatic void model_write(pvr_addr_t addr, pvr_word_t data);
		pvr_addr_t offset;
		offset = addr & 16'hFFFC;
		if (offset <= REG_WINDOW_END && offset != ID_ADDR && offset != REVISION_ADDR) begin
			reg_model[offset >> 2] = data;
		end else if (offset >= PAL_BASE && offset <= PAL_END) begin
			pal_model[(offset - PAL_BASE) >> 2] = data;
		end
	endfunction

	task automatic check_word(string name, pvr_word_t actual, pvr_word_t expected);
		if (actual !== expected) begin
			$display("Mismatch at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
			error_count++;
		end
	endtask

	task automatic check_count(string name, count_t actual, count_t expected);
		if (actual !== expected) begin
			$display("Mismatch at %0t ns: %s = %0d, expected %0d", $time, name, actual, expected);
			error_count++;
		end
	endtask

	task automatic check_flag(string name, logic actual, logic expected);
		if (actual !== expected) begin
			$display("Mismatch at %0t ns: %s = %b, expected %b", $time, name, actual, expected);
			error_count++;
		end
	endtask

	task automatic report_timeout(string what);
		$display("Timeout at %0t ns: %s did not settle within %0d cycles", $time, what,
			WAIT_LIMIT);
		error_count++;
	endtask

	// one cycle of inputs applied on the rising edge
	task automatic drive(logic cs, pvr_addr_t addr, pvr_word_t din, logic rd, logic wr,
			logic push, logic pop);
		@(posedge clock);
		pvr_reg_cs_i <= cs;
		pvr_addr_i   <= addr;
		pvr_din_i    <= din;
		pvr_rd_i     <= rd;
		pvr_wr_i     <= wr;
		ta_fifo_wr_i <= push;
		ta_rd_i      <= pop;
	endtask

	task automatic host_write(pvr_addr_t addr, pvr_word_t data);
		drive(1'b1, addr, data, 1'b0, 1'b1, 1'b0, 1'b0);
	endtask

	task automatic host_read(pvr_addr_t addr, logic cs, logic rd);
		drive(cs, addr, '0, rd, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic fifo_push(pvr_word_t data);
		drive(1'b0, '0, data, 1'b0, 1'b0, 1'b1, 1'b0);
	endtask

	task automatic fifo_pop();
		drive(1'b0, '0, '0, 1'b0, 1'b0, 1'b0, 1'b1);
	endtask

	task automatic idle_cycle();
		drive(1'b0, '0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic drain_fifo();
		int guard;
		guard = 0;
		@(negedge clock);
		while (ta_empty_o !== 1'b1 && guard < WAIT_LIMIT) begin	// pop until empty
			fifo_pop();
			@(negedge clock);
			guard++;
		end
		if (ta_empty_o !== 1'b1) report_timeout("ta_empty_o");
		idle_cycle();
	endtask

	task automatic end_test(string name);
		int errs;
		errs = error_count - test_errors;
		$display("test %-30s %0d errors", name, errs);
		if (errs == 0) tests_passed++;
		else tests_failed++;
		test_errors = error_count;
	endtask

	// reference model updated at the edge where the dut captures
	always @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			for (int i = 0; i < REG_WORDS; i++) begin
				reg_model[i] = '0;
			end
			fifo_q.delete();
			fifo_last = '0;
		end else begin
			can_pop  = ta_rd_i && (fifo_q.size() > 0);		// state before this edge
			can_push = ta_fifo_wr_i && (fifo_q.size() < DEPTH);
			if (pvr_reg_cs_i && pvr_wr_i) model_write(pvr_addr_i, pvr_din_i);
			if (can_pop) fifo_last = fifo_q.pop_front();
			if (can_push) fifo_q.push_back(pvr_din_i);	// word dropped when full
		end
	end

	// compare every cycle at the falling edge where outputs are settled
	always @(negedge clock) begin
		if (reset_n === 1'b1) begin
			check_word("pvr_dout_o", pvr_dout_o,
				expected_read(pvr_addr_i, pvr_reg_cs_i, pvr_rd_i));
			check_word("ta_data_o", ta_data_o, fifo_last);
			check_count("ta_words_o", ta_words_o, count_t'(fifo_q.size()));
			check_flag("ta_full_o", ta_full_o, fifo_q.size() == DEPTH);
			check_flag("ta_empty_o", ta_empty_o, fifo_q.size() == 0);
		end
	end

	initial begin
		int        n;
		int        guard;
		pvr_word_t held;
		pvr_word_t data;
		pvr_addr_t addr;
		reset_n <= 1'b0;
		pvr_reg_cs_i <= 1'b0;
		pvr_addr_i <= '0;
		pvr_din_i <= '0;
		pvr_rd_i <= 1'b0;
		pvr_wr_i <= 1'b0;
		ta_fifo_wr_i <= 1'b0;
		ta_rd_i <= 1'b0;
		repeat (4) @(posedge clock);
		reset_n <= 1'b1;

		for (int i = 0; i < REG_WORDS; i++) begin	// id, revision, then zeros
			host_read(pvr_addr_t'(i * 4), 1'b1, 1'b1);
		end
		host_write(ID_ADDR, 32'hFFFF_FFFF);		// both must be ignored
		host_write(REVISION_ADDR, 32'h0);
		host_read(ID_ADDR, 1'b1, 1'b1);
		host_read(REVISION_ADDR, 1'b1, 1'b1);
		idle_cycle();
		end_test("reset values and fixed words");

		for (int i = 0; i < 64; i++) begin
			addr = pvr_addr_t'((2 + next_rand() % 254) * 4);	// skip id and revision
			host_write(addr, next_rand());
		end
		for (int i = 0; i < REG_WORDS; i++) begin
			host_read(pvr_addr_t'(i * 4), 1'b1, 1'b1);
		end
		for (int i = 0; i < 32; i++) begin
			addr = pvr_addr_t'((next_rand() % REG_WORDS) * 4);
			host_read(addr, i[0], ~i[0]);	// cs or rd low reads zero
		end
		idle_cycle();
		end_test("register window");

		for (int i = 0; i < PAL_WORDS; i++) begin	// palette has no reset
			host_write(PAL_BASE + pvr_addr_t'(i * 4), next_rand());
		end
		for (int i = 0; i < 200; i++) begin
			host_write(PAL_BASE + pvr_addr_t'((next_rand() % PAL_WORDS) * 4), next_rand());
		end
		host_write(16'h0600, next_rand());
		host_write(16'h2000, next_rand());
		for (int i = 0; i < 16; i++) begin
			addr = pvr_addr_t'(next_rand()) | 16'h2000;	// anywhere at or above 0x2000
			host_write(addr, next_rand());
			host_read(addr, 1'b1, 1'b1);
		end
		host_read(16'h0600, 1'b1, 1'b1);
		host_read(16'h2000, 1'b1, 1'b1);
		for (int i = 0; i < PAL_WORDS; i++) begin
			host_read(PAL_BASE + pvr_addr_t'(i * 4), 1'b1, 1'b1);
		end
		for (int i = 0; i < REG_WORDS; i++) begin	// no alias into the window
			host_read(pvr_addr_t'(i * 4), 1'b1, 1'b1);
		end
		idle_cycle();
		end_test("palette and unmapped space");

		n = 1 + next_rand() % DEPTH;
		for (int i = 0; i < n; i++) begin
			fifo_push(next_rand());
		end
		idle_cycle();
		@(negedge clock);
		check_count("ta_words_o", ta_words_o, count_t'(n));
		drain_fifo();
		end_test("fifo push and pop in order");

		held = '0;
		for (int i = 0; i < DEPTH + 4; i++) begin	// last four are dropped
			data = next_rand();
			if (i == DEPTH - 1) held = data;	// last word that fits
			fifo_push(data);
		end
		idle_cycle();
		guard = 0;
		@(negedge clock);
		while (ta_full_o !== 1'b1 && guard < WAIT_LIMIT) begin
			idle_cycle();
			@(negedge clock);
			guard++;
		end
		if (ta_full_o !== 1'b1) report_timeout("ta_full_o");
		drain_fifo();
		@(negedge clock);
		check_word("ta_data_o", ta_data_o, held);
		fifo_pop();		// pop while empty
		idle_cycle();
		@(negedge clock);
		check_word("ta_data_o", ta_data_o, held);
		end_test("fifo overflow and empty pop");

		assert_fails = u_pvr_top.u_ta_fifo.u_fifo_assertions.fail_count;
		error_count += assert_fails;
		$display("tests passed %0d, failed %0d, assertion failures %0d, errors %0d",
			tests_passed, tests_failed, assert_fails, error_count);
		if (error_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
logic/pvr_pkg.sv
logic/pvr_bus_if.sv
logic/pvr_bus_decode.sv
logic/pvr_reg_file.sv
logic/pvr_palette_ram.sv
logic/ta_fifo.sv
logic/pvr_top.sv
testbench/pvr_assertions.sv
testbench/pvr_tb.sv
